/* src/resolver_pkg.sv */
// Resolver converter definitions
package resolver_pkg;

    localparam int register_count = 9;

    // Device addresses in upload order
    localparam logic [7:0] device_address_table [register_count] = '{
        8'h88, 8'h89, 8'h8A, 8'h8B, 8'h8C, 8'h8D, 8'h8E, 8'h91, 8'h92
    };

    // Command and control sit above the value slots at 0x00 to 0x20
    localparam logic [31:0] command_offset = 32'h24;
    localparam logic [31:0] control_offset = 32'h28;

    localparam logic [1:0] mode_angle = 2'd0;
    localparam logic [1:0] mode_speed = 2'd2;
    localparam logic [1:0] mode_config = 2'd3;

    typedef struct packed {
        logic [2:0] spare_top;
        logic [4:0] transfer_length;
        logic [7:0] sample_read_delay;
        logic [7:0] sample_pulse_length;
        logic [2:0] spare_low;
        logic rdc_reset;
        logic [1:0] resolution;
        logic [1:0] spare_bottom;
    } control_fields_t;

    localparam control_fields_t control_reset = '{
        resolution: 2'b10,
        transfer_length: 5'd22,
        sample_pulse_length: 8'd1,
        sample_read_delay: 8'd1,
        default: '0
    };

    // One bus word seen as a register byte or as the control word
    typedef union packed {
        struct packed {
            logic [23:0] padding;
            logic [7:0] value;
        } register_byte;
        control_fields_t control;
    } write_word_u;

    typedef enum logic {
        kind_angle = 1'b0,
        kind_speed = 1'b1
    } read_kind_t;

endpackage

/* src/bus_pkg.sv */
// Bus, SPI and stream beat types
package bus_pkg;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        logic strobe;
    } bus_write_t;

    typedef struct packed {
        logic [31:0] data;
        logic valid;
    } spi_request_t;

    // Upper 24 bits of the SPI word in data, low byte in user
    typedef struct packed {
        logic [31:0] data;
        logic [7:0] user;
        resolver_pkg::read_kind_t dest;
        logic valid;
    } result_beat_t;

endpackage

/* src/resolver_registers.sv */
// Resolver register bank
`timescale 1ns/1ps

module resolver_registers #(
    parameter logic [31:0] base_address = 32'h43c00000
) (
    input logic clock,
    input logic reset,
    input bus_pkg::bus_write_t bus_write,
    input logic accept,
    output logic [7:0] register_values [resolver_pkg::register_count],
    output resolver_pkg::control_fields_t control
);

    logic pending;
    logic [31:0] offset;
    resolver_pkg::write_word_u word;
    logic [29:0] slot;
    logic store_value;
    logic store_control;

    always_ff @(posedge clock) begin
        if (!reset) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    // Shadow copy of the accepted write
    always_ff @(posedge clock) begin
        if (accept) begin
            offset <= bus_write.address - base_address;
            word <= bus_write.data;
        end
    end

    assign slot = offset[31:2];
    assign store_value = pending && offset[1:0] == 2'b00
        && slot < resolver_pkg::register_count;
    assign store_control = pending && offset == resolver_pkg::control_offset;

    // One byte per word offset
    always_ff @(posedge clock) begin
        if (store_value) begin
            register_values[slot[3:0]] <= word.register_byte.value;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            control <= resolver_pkg::control_reset;
        end else if (store_control) begin
            control <= word.control;
        end
    end

    // Every accepted write lands on a mapped offset
    assert property (@(posedge clock) disable iff (!reset)
        accept |=> store_value || store_control
            || offset == resolver_pkg::command_offset);

endmodule

/* src/config_sequencer.sv */
// Configuration upload sequencer
`timescale 1ns/1ps

module config_sequencer (
    input logic clock,
    input logic reset,
    input logic start,
    input logic spi_ready,
    input logic [7:0] register_values [resolver_pkg::register_count],
    output bus_pkg::spi_request_t spi_request,
    output logic done
);

    typedef enum logic [1:0] {
        config_idle,
        config_address,
        config_value,
        config_finish
    } config_state_t;

    config_state_t state;
    logic [3:0] index;
    logic send_slot;

    // Engine is free and has seen no request yet
    assign send_slot = spi_ready && !spi_request.valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= config_idle;
            index <= 4'd0;
            spi_request <= '0;
            done <= 1'b0;
        end else begin
            spi_request.valid <= 1'b0;
            done <= 1'b0;
            case (state)
                config_idle: begin
                    if (start) begin
                        index <= 4'd0;
                        state <= config_address;
                    end
                end
                config_address: begin
                    if (send_slot) begin
                        spi_request.data <= {24'd0, resolver_pkg::device_address_table[index]};
                        spi_request.valid <= 1'b1;
                        state <= config_value;
                    end
                end
                config_value: begin
                    if (send_slot) begin
                        spi_request.data <= {24'd0, register_values[index]};
                        spi_request.valid <= 1'b1;
                        if (index == 4'(resolver_pkg::register_count - 1)) begin
                            state <= config_finish;
                        end else begin
                            index <= index + 4'd1;
                            state <= config_address;
                        end
                    end
                end
                config_finish: begin
                    // Last byte must be out before done
                    if (send_slot) begin
                        done <= 1'b1;
                        state <= config_idle;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        spi_request.valid |-> spi_ready);

endmodule

/* src/sample_reader.sv */
// Angle and speed sample reader
`timescale 1ns/1ps

module sample_reader (
    input logic clock,
    input logic reset,
    input logic start,
    input resolver_pkg::read_kind_t kind,
    input logic spi_ready,
    input logic [31:0] spi_data_in,
    input resolver_pkg::control_fields_t control,
    output logic sample,
    output logic [1:0] mode,
    output bus_pkg::spi_request_t spi_request,
    output bus_pkg::result_beat_t result,
    output logic done
);

    typedef enum logic [2:0] {
        reader_idle,
        reader_pulse,
        reader_delay,
        reader_transfer,
        reader_backoff
    } reader_state_t;

    reader_state_t state;
    logic [7:0] counter;
    resolver_pkg::read_kind_t active_kind;
    logic send_slot;
    logic pulse_end;

    assign send_slot = spi_ready && !spi_request.valid;
    assign pulse_end = counter == control.sample_pulse_length - 8'd1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= reader_idle;
            counter <= 8'd0;
            active_kind <= resolver_pkg::kind_angle;
            sample <= 1'b1;
            mode <= resolver_pkg::mode_angle;
            spi_request <= '0;
            result <= '0;
            done <= 1'b0;
        end else begin
            spi_request.valid <= 1'b0;
            result.valid <= 1'b0;
            done <= 1'b0;
            case (state)
                reader_idle: begin
                    if (start) begin
                        active_kind <= kind;
                        mode <= kind == resolver_pkg::kind_speed
                            ? resolver_pkg::mode_speed : resolver_pkg::mode_angle;
                        sample <= 1'b0;
                        counter <= 8'd0;
                        state <= reader_pulse;
                    end
                end
                reader_pulse: begin
                    if (pulse_end) begin
                        sample <= 1'b1;
                        counter <= 8'd0;
                        state <= reader_delay;
                    end else begin
                        counter <= counter + 8'd1;
                    end
                end
                reader_delay: begin
                    if (counter != control.sample_read_delay) begin
                        counter <= counter + 8'd1;
                    end else if (send_slot) begin
                        // Dummy word clocks the sample out
                        spi_request.data <= 32'd0;
                        spi_request.valid <= 1'b1;
                        state <= reader_transfer;
                    end
                end
                reader_transfer: begin
                    if (send_slot) begin
                        result.data <= {8'd0, spi_data_in[31:8]};
                        result.user <= spi_data_in[7:0];
                        result.dest <= active_kind;
                        result.valid <= 1'b1;
                        counter <= 8'd0;
                        state <= reader_backoff;
                    end
                end
                reader_backoff: begin
                    if (pulse_end) begin
                        done <= 1'b1;
                        state <= reader_idle;
                    end else begin
                        counter <= counter + 8'd1;
                    end
                end
                default: begin
                    state <= reader_idle;
                end
            endcase
        end
    end

    // One beat per read
    assert property (@(posedge clock) disable iff (!reset)
        result.valid |=> !result.valid);

endmodule

/* src/resolver_control.sv */
// Resolver control state machine
`timescale 1ns/1ps

module resolver_control #(
    parameter logic [31:0] base_address = 32'h43c00000
) (
    input logic clock,
    input logic reset,
    input bus_pkg::bus_write_t bus_write,
    input logic read_angle,
    input logic read_speed,
    input logic config_done,
    input logic read_done,
    input bus_pkg::spi_request_t config_request,
    input bus_pkg::spi_request_t read_request,
    input logic [1:0] read_mode,
    output logic bus_ready,
    output logic accept,
    output logic config_start,
    output logic read_start,
    output resolver_pkg::read_kind_t read_kind,
    output bus_pkg::spi_request_t spi_request,
    output logic [1:0] mode
);

    typedef enum logic [1:0] {
        control_idle,
        control_act,
        control_configure,
        control_read
    } control_state_t;

    control_state_t state;
    logic [31:0] offset;
    logic command_zero;
    logic write_taken;

    assign offset = bus_write.address - base_address;
    assign command_zero = offset == resolver_pkg::command_offset && bus_write.data == 32'd0;

    // Read strobes win over the bus
    assign write_taken = state == control_idle && bus_ready && bus_write.strobe
        && !read_angle && !read_speed;
    assign accept = write_taken && !command_zero;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= control_idle;
            bus_ready <= 1'b1;
            config_start <= 1'b0;
            read_start <= 1'b0;
            read_kind <= resolver_pkg::kind_angle;
        end else begin
            config_start <= 1'b0;
            read_start <= 1'b0;
            case (state)
                control_idle: begin
                    if (read_angle || read_speed) begin
                        read_kind <= read_angle ? resolver_pkg::kind_angle
                            : resolver_pkg::kind_speed;
                        read_start <= 1'b1;
                        bus_ready <= 1'b0;
                        state <= control_read;
                    end else if (write_taken) begin
                        bus_ready <= 1'b0;
                        if (command_zero) begin
                            config_start <= 1'b1;
                            state <= control_configure;
                        end else begin
                            state <= control_act;
                        end
                    end
                end
                control_act: begin
                    bus_ready <= 1'b1;
                    state <= control_idle;
                end
                control_configure: begin
                    if (config_done) begin
                        bus_ready <= 1'b1;
                        state <= control_idle;
                    end
                end
                control_read: begin
                    if (read_done) begin
                        bus_ready <= 1'b1;
                        state <= control_idle;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            control_configure: spi_request = config_request;
            control_read: spi_request = read_request;
            default: spi_request = '0;
        endcase
    end

    assign mode = state == control_configure ? resolver_pkg::mode_config : read_mode;

    // Each sequencer talks only while it owns the port
    assert property (@(posedge clock) disable iff (!reset)
        (config_request.valid |-> state == control_configure)
        and (read_request.valid |-> state == control_read));

endmodule

/* src/resolver_interface_top.sv */
// Resolver interface top level
`timescale 1ns/1ps

module resolver_interface_top #(
    parameter logic [31:0] base_address = 32'h43c00000
) (
    input logic clock,
    input logic reset,
    input logic read_angle,
    input logic read_speed,
    input logic spi_ready,
    input logic [31:0] spi_data_in,
    input bus_pkg::bus_write_t bus_write,
    output logic bus_ready,
    output bus_pkg::spi_request_t spi_request,
    output logic [1:0] mode,
    output logic sample,
    output logic [1:0] resolution,
    output logic rdc_reset,
    output logic [4:0] transfer_length,
    output bus_pkg::result_beat_t result
);

    logic [7:0] register_values [resolver_pkg::register_count];
    resolver_pkg::control_fields_t control;
    resolver_pkg::read_kind_t read_kind;
    bus_pkg::spi_request_t config_request;
    bus_pkg::spi_request_t read_request;
    logic [1:0] read_mode;
    logic accept;
    logic config_start;
    logic config_done;
    logic read_start;
    logic read_done;

    assign resolution = control.resolution;
    assign rdc_reset = control.rdc_reset;
    assign transfer_length = control.transfer_length;

    resolver_registers #(
        .base_address(base_address)
    ) resolver_registers_inst (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .accept(accept),
        .register_values(register_values),
        .control(control)
    );

    config_sequencer config_sequencer_inst (
        .clock(clock),
        .reset(reset),
        .start(config_start),
        .spi_ready(spi_ready),
        .register_values(register_values),
        .spi_request(config_request),
        .done(config_done)
    );

    sample_reader sample_reader_inst (
        .clock(clock),
        .reset(reset),
        .start(read_start),
        .kind(read_kind),
        .spi_ready(spi_ready),
        .spi_data_in(spi_data_in),
        .control(control),
        .sample(sample),
        .mode(read_mode),
        .spi_request(read_request),
        .result(result),
        .done(read_done)
    );

    resolver_control #(
        .base_address(base_address)
    ) resolver_control_inst (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .read_angle(read_angle),
        .read_speed(read_speed),
        .config_done(config_done),
        .read_done(read_done),
        .config_request(config_request),
        .read_request(read_request),
        .read_mode(read_mode),
        .bus_ready(bus_ready),
        .accept(accept),
        .config_start(config_start),
        .read_start(read_start),
        .read_kind(read_kind),
        .spi_request(spi_request),
        .mode(mode)
    );

endmodule

/* testbench/spi_device_model.sv */
// SPI engine and converter model
`timescale 1ns/1ps

module spi_device_model (
    input logic clock,
    input bus_pkg::spi_request_t spi_request,
    input logic [31:0] reply_word,
    output logic spi_ready,
    output logic [31:0] spi_data_in
);

    integer seed = 32'h32f7;
    int hold;

    initial begin
        spi_ready = 1'b1;
        spi_data_in = 32'd0;
        forever begin
            @(posedge clock);
            #1;
            if (spi_request.valid) begin
                // Busy from the cycle after the request
                @(posedge clock);
                #1;
                spi_ready = 1'b0;
                hold = 2 + int'({$random(seed)} % 8);
                repeat (hold) @(posedge clock);
                #1;
                // Converter word is valid together with ready
                spi_data_in = reply_word;
                spi_ready = 1'b1;
            end
        end
    end

endmodule

/* testbench/tb_resolver.sv */
// Resolver interface testbench
`timescale 1ns/1ps

module tb_resolver;

    localparam logic [31:0] base_address = 32'h43c00000;

    logic clock;
    logic reset;
    logic read_angle;
    logic read_speed;
    logic spi_ready;
    logic [31:0] spi_data_in;
    bus_pkg::bus_write_t bus_write;
    logic bus_ready;
    bus_pkg::spi_request_t spi_request;
    logic [1:0] mode;
    logic sample;
    logic [1:0] resolution;
    logic rdc_reset;
    logic [4:0] transfer_length;
    bus_pkg::result_beat_t result;

    integer seed = 32'h32f7;
    logic [31:0] reply_word;
    logic [7:0] written_values [resolver_pkg::register_count];
    resolver_pkg::control_fields_t control_word;
    logic [7:0] sent_bytes [$];
    logic uploading;
    int check_count;
    int error_count;
    int beat_count;
    int low_cycles;
    int ready_wait;
    bus_pkg::result_beat_t last_beat;
    logic [1:0] beat_mode;

    resolver_interface_top #(
        .base_address(base_address)
    ) resolver_interface_top_inst (
        .clock(clock),
        .reset(reset),
        .read_angle(read_angle),
        .read_speed(read_speed),
        .spi_ready(spi_ready),
        .spi_data_in(spi_data_in),
        .bus_write(bus_write),
        .bus_ready(bus_ready),
        .spi_request(spi_request),
        .mode(mode),
        .sample(sample),
        .resolution(resolution),
        .rdc_reset(rdc_reset),
        .transfer_length(transfer_length),
        .result(result)
    );

    spi_device_model spi_device_model_inst (
        .clock(clock),
        .spi_request(spi_request),
        .reply_word(reply_word),
        .spi_ready(spi_ready),
        .spi_data_in(spi_data_in)
    );

    always #2 clock = ~clock;

    // Address byte then value byte for each register
    function automatic logic [7:0] expected_upload_byte(input int position);
        if (position % 2 == 0) begin
            return resolver_pkg::device_address_table[position / 2];
        end
        return written_values[position / 2];
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        error_count++;
        $display("Timeout at %0t: %s never came", $time, what);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_for_ready(input int limit);
        int cycles;
        cycles = 0;
        while (!bus_ready) begin
            if (cycles == limit) begin
                stop_on_timeout("bus_ready");
            end
            @(posedge clock);
            #1;
            cycles++;
        end
        ready_wait = cycles;
    endtask

    task automatic write_register(input logic [31:0] offset, input logic [31:0] data);
        bus_write.address = base_address + offset;
        bus_write.data = data;
        bus_write.strobe = 1'b1;
        @(posedge clock);
        #1;
        bus_write.strobe = 1'b0;
        wait_for_ready(1000);
    endtask

    task automatic run_read(input resolver_pkg::read_kind_t kind, input logic [1:0] expected_mode);
        reply_word = $random(seed);
        beat_count = 0;
        low_cycles = 0;
        if (kind == resolver_pkg::kind_angle) begin
            read_angle = 1'b1;
        end else begin
            read_speed = 1'b1;
        end
        @(posedge clock);
        #1;
        read_angle = 1'b0;
        read_speed = 1'b0;
        wait_for_ready(400);
        check_value("result beats", 32'(beat_count), 32'd1);
        check_value("result data", last_beat.data, reply_word >> 8);
        check_value("result user", 32'(last_beat.user), 32'(reply_word[7:0]));
        check_value("result dest", 32'(last_beat.dest), 32'(kind));
        check_value("read mode", 32'(beat_mode), 32'(expected_mode));
        check_value("sample low cycles", 32'(low_cycles), 32'(control_word.sample_pulse_length));
    endtask

    // Monitor samples on the falling edge
    always @(negedge clock) begin
        if (reset) begin
            assert (spi_ready || !spi_request.valid) else begin
                $display("SPI request sent at %0t while spi_ready was low", $time);
                error_count++;
            end
            if (spi_request.valid && uploading) begin
                sent_bytes.push_back(spi_request.data[7:0]);
                assert (mode == resolver_pkg::mode_config) else begin
                    $display("Fail at %0t: mode is %0d during upload", $time, mode);
                    error_count++;
                end
            end
            if (result.valid) begin
                beat_count++;
                last_beat = result;
                beat_mode = mode;
            end
            if (!sample) begin
                low_cycles++;
            end
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        read_angle = 1'b0;
        read_speed = 1'b0;
        bus_write = '0;
        reply_word = 32'd0;
        uploading = 1'b0;
        control_word = '0;
        check_count = 0;
        error_count = 0;
        beat_count = 0;
        low_cycles = 0;
        ready_wait = 0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;

        check_value("resolution", 32'(resolution), 32'h2);
        check_value("transfer_length", 32'(transfer_length), 32'd22);
        check_value("rdc_reset", 32'(rdc_reset), 32'd0);
        check_value("sample", 32'(sample), 32'd1);
        check_value("bus_ready", 32'(bus_ready), 32'd1);
        check_value("result valid", 32'(result.valid), 32'd0);

        control_word.resolution = 2'b01;
        control_word.rdc_reset = 1'b1;
        control_word.sample_pulse_length = 8'd3;
        control_word.sample_read_delay = 8'd4;
        control_word.transfer_length = 5'd16;
        write_register(resolver_pkg::control_offset, control_word);
        check_value("resolution", 32'(resolution), 32'h1);
        check_value("rdc_reset", 32'(rdc_reset), 32'd1);
        check_value("transfer_length", 32'(transfer_length), 32'd16);
        // bus_ready low for the one cycle after the strobe
        check_value("bus_ready wait cycles", 32'(ready_wait), 32'd1);

        for (int i = 0; i < resolver_pkg::register_count; i++) begin
            written_values[i] = 8'($random(seed));
            write_register(32'(4 * i), 32'(written_values[i]));
        end
        sent_bytes.delete();
        uploading = 1'b1;
        write_register(resolver_pkg::command_offset, 32'd0);
        uploading = 1'b0;
        check_value("upload length", 32'(sent_bytes.size()),
                    32'(2 * resolver_pkg::register_count));
        for (int i = 0; i < sent_bytes.size() && i < 2 * resolver_pkg::register_count; i++) begin
            check_value("upload byte", 32'(sent_bytes[i]), 32'(expected_upload_byte(i)));
        end

        run_read(resolver_pkg::kind_angle, resolver_pkg::mode_angle);
        run_read(resolver_pkg::kind_speed, resolver_pkg::mode_speed);
        // Back to angle so mode and dest must change again
        run_read(resolver_pkg::kind_angle, resolver_pkg::mode_angle);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
src/resolver_pkg.sv
src/bus_pkg.sv
src/resolver_registers.sv
src/config_sequencer.sv
src/sample_reader.sv
src/resolver_control.sv
src/resolver_interface_top.sv
testbench/spi_device_model.sv
testbench/tb_resolver.sv

/* run.sh */
#!/bin/sh
# Compile and run the resolver testbench with Verilator
set -e

verilator --binary --timing --assert -f list.f --top-module tb_resolver -o sim_resolver
./obj_dir/sim_resolver | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
